// ==== nebula_pkg.sv ====
/* Shared bus widths, address map, GPIO sizes and the types built on them */
package nebula_pkg;

    // Wishbone bus widths
    localparam int WB_ADR_W = 32;
    localparam int WB_DAT_W = 32;
    localparam int WB_SEL_W = 4;   // One select bit per byte lane

    typedef logic [WB_ADR_W-1:0] wb_adr_t;
    typedef logic [WB_DAT_W-1:0] wb_dat_t;
    typedef logic [WB_SEL_W-1:0] wb_sel_t;

    // Host processor and one team manager
    localparam int NUM_MANAGERS = 2;

    // Team designs competing for pads
    localparam int NUM_TEAMS  = 4;
    localparam int TEAM_IDX_W = 2;

    typedef logic [TEAM_IDX_W-1:0] team_idx_t;

    localparam int GPIO_PINS = 8;

    typedef logic [GPIO_PINS-1:0] gpio_bus_t;
    typedef gpio_bus_t [NUM_TEAMS-1:0] team_gpio_t;   // One pad pattern per team

    // RAM depth in words
    localparam int RAM_WORDS = 64;

    // Address map, region picked by the top byte
    localparam wb_adr_t REGION_MASK = 32'hFF00_0000;
    localparam wb_adr_t RAM_BASE    = 32'h3000_0000;
    localparam wb_adr_t GPIO_BASE   = 32'h3100_0000;

endpackage

// ==== wb_if.sv ====
/* Wishbone classic bus bundle with manager and subordinate views */
`timescale 1ns/1ps

interface wb_if import nebula_pkg::*; ();

    logic    cyc;
    logic    stb;
    logic    we;
    wb_sel_t sel;
    wb_adr_t adr;
    wb_dat_t wdat;   // Manager to subordinate
    logic    ack;
    wb_dat_t rdat;   // Subordinate to manager

    modport manager (
        output cyc,
        output stb,
        output we,
        output sel,
        output adr,
        output wdat,
        input  ack,
        input  rdat
    );

    modport subordinate (
        input  cyc,
        input  stb,
        input  we,
        input  sel,
        input  adr,
        input  wdat,
        output ack,
        output rdat
    );

endinterface

// ==== wb_arbiter.sv ====
/* Round-robin arbiter placing one of the manager ports onto the shared bus */
`timescale 1ns/1ps

module wb_arbiter import nebula_pkg::*; (
    input  logic                       clk,
    input  logic                       asyncrst_n,
    input  logic [NUM_MANAGERS-1:0]    m_cyc_i,
    input  logic [NUM_MANAGERS-1:0]    m_stb_i,
    input  logic [NUM_MANAGERS-1:0]    m_we_i,
    input  wb_sel_t [NUM_MANAGERS-1:0] m_sel_i,
    input  wb_adr_t [NUM_MANAGERS-1:0] m_adr_i,
    input  wb_dat_t [NUM_MANAGERS-1:0] m_wdat_i,
    output logic [NUM_MANAGERS-1:0]    m_ack_o,
    output wb_dat_t                    m_rdat_o,
    wb_if.manager                      bus
);

    typedef logic [$clog2(NUM_MANAGERS)-1:0] mgr_idx_t;

    logic [NUM_MANAGERS-1:0] req;
    mgr_idx_t                pick;
    logic                    pick_valid;
    int                      cand;
    logic                    gnt_valid_q;
    mgr_idx_t                gnt_idx_q;
    mgr_idx_t                last_q;       // Manager served most recently

    assign req = m_cyc_i & m_stb_i;

    // Search starts one past the last manager served
    always_comb begin
        pick       = last_q;
        pick_valid = 1'b0;
        cand       = 0;
        for (int k = 1; k <= NUM_MANAGERS; k++) begin
            cand = (int'(last_q) + k) % NUM_MANAGERS;
            if (!pick_valid && req[cand]) begin
                pick       = mgr_idx_t'(cand);
                pick_valid = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge asyncrst_n) begin
        if (!asyncrst_n) begin
            gnt_valid_q <= 1'b0;
            gnt_idx_q   <= '0;
            last_q      <= mgr_idx_t'(NUM_MANAGERS - 1);   // So the host wins first
        end else if (gnt_valid_q) begin
            // Drop grant after ack, or if the owner abandons its cycle
            if (bus.ack || !m_cyc_i[gnt_idx_q]) begin
                gnt_valid_q <= 1'b0;
            end
        end else if (pick_valid) begin
            gnt_valid_q <= 1'b1;
            gnt_idx_q   <= pick;
            last_q      <= pick;
        end
    end

    // Granted manager's request onto the bus
    assign bus.cyc  = gnt_valid_q & m_cyc_i[gnt_idx_q];
    assign bus.stb  = gnt_valid_q & m_stb_i[gnt_idx_q];
    assign bus.we   = m_we_i[gnt_idx_q];
    assign bus.sel  = m_sel_i[gnt_idx_q];
    assign bus.adr  = m_adr_i[gnt_idx_q];
    assign bus.wdat = m_wdat_i[gnt_idx_q];

    assign m_rdat_o = bus.rdat;   // Only meaningful alongside ack

    always_comb begin
        m_ack_o            = '0;
        m_ack_o[gnt_idx_q] = gnt_valid_q & bus.ack;
    end

endmodule

// ==== wb_decoder.sv ====
/* Region decode from the shared bus to the RAM and GPIO control,
   with a local reply for unmapped addresses */
`timescale 1ns/1ps

module wb_decoder import nebula_pkg::*; (
    input  logic         clk,
    input  logic         asyncrst_n,
    wb_if.subordinate    up,
    wb_if.manager        ram,
    wb_if.manager        gpio
);

    wb_adr_t region;
    logic    hit_ram;
    logic    hit_gpio;
    logic    unmapped;
    logic    nomap_ack_q;

    assign region   = up.adr & REGION_MASK;
    assign hit_ram  = (region == RAM_BASE);
    assign hit_gpio = (region == GPIO_BASE);
    assign unmapped = !hit_ram && !hit_gpio;

    // Request fields fan out, only cyc and stb are qualified
    assign ram.cyc  = up.cyc & hit_ram;
    assign ram.stb  = up.stb & hit_ram;
    assign ram.we   = up.we;
    assign ram.sel  = up.sel;
    assign ram.adr  = up.adr;
    assign ram.wdat = up.wdat;

    assign gpio.cyc  = up.cyc & hit_gpio;
    assign gpio.stb  = up.stb & hit_gpio;
    assign gpio.we   = up.we;
    assign gpio.sel  = up.sel;
    assign gpio.adr  = up.adr;
    assign gpio.wdat = up.wdat;

    // One-cycle ack for addresses nobody claims
    always_ff @(posedge clk or negedge asyncrst_n) begin
        if (!asyncrst_n) begin
            nomap_ack_q <= 1'b0;
        end else begin
            nomap_ack_q <= up.cyc & up.stb & unmapped & ~nomap_ack_q;
        end
    end

    // Reply mux back to the manager side
    always_comb begin
        up.ack  = nomap_ack_q;
        up.rdat = '0;   // Unmapped reads return zero
        if (hit_ram) begin
            up.ack  = ram.ack;
            up.rdat = ram.rdat;
        end else if (hit_gpio) begin
            up.ack  = gpio.ack;
            up.rdat = gpio.rdat;
        end
    end

endmodule

// ==== ffram.sv ====
/* Word RAM on the Wishbone bus with per-byte-lane writes */
`timescale 1ns/1ps

module ffram import nebula_pkg::*; (
    input  logic      clk,
    input  logic      asyncrst_n,
    wb_if.subordinate bus
);

    wb_dat_t                      mem [RAM_WORDS];
    logic [$clog2(RAM_WORDS)-1:0] word_idx;
    logic                         access;
    logic                         ack_q;
    wb_dat_t                      rdat_q;

    // Word index above the byte offset, wraps within the depth
    assign word_idx = bus.adr[$clog2(WB_SEL_W) +: $clog2(RAM_WORDS)];

    // Accept once per request, never two acks back to back
    assign access = bus.cyc & bus.stb & ~ack_q;

    always_ff @(posedge clk or negedge asyncrst_n) begin
        if (!asyncrst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            rdat_q <= mem[word_idx];
            if (bus.we) begin
                for (int b = 0; b < WB_SEL_W; b++) begin
                    if (bus.sel[b]) begin
                        mem[word_idx][b*(WB_DAT_W/WB_SEL_W) +: WB_DAT_W/WB_SEL_W] <=
                            bus.wdat[b*(WB_DAT_W/WB_SEL_W) +: WB_DAT_W/WB_SEL_W];
                    end
                end
            end
        end
    end

    assign bus.ack  = ack_q;
    assign bus.rdat = rdat_q;

endmodule

// ==== gpio_control.sv ====
/* Per-pad team select registers on Wishbone and the pad output routing */
`timescale 1ns/1ps

module gpio_control import nebula_pkg::*; (
    input  logic       clk,
    input  logic       asyncrst_n,
    wb_if.subordinate  bus,
    input  team_gpio_t team_gpio_out_i,
    input  team_gpio_t team_gpio_oeb_i,
    output gpio_bus_t  io_out_o,
    output gpio_bus_t  io_oeb_o
);

    team_idx_t                    pad_sel [GPIO_PINS];   // Owner of each pad
    wb_adr_t                      word_off;
    logic [$clog2(GPIO_PINS)-1:0] pad_idx;
    logic                         in_range;
    logic                         access;
    logic                         ack_q;
    wb_dat_t                      rdat_q;

    // Word offset inside the GPIO region
    assign word_off = (bus.adr & ~REGION_MASK) >> $clog2(WB_SEL_W);
    assign pad_idx  = word_off[$clog2(GPIO_PINS)-1:0];
    assign in_range = (word_off < GPIO_PINS);
    assign access   = bus.cyc & bus.stb & ~ack_q;

    always_ff @(posedge clk or negedge asyncrst_n) begin
        if (!asyncrst_n) begin
            ack_q <= 1'b0;
            for (int p = 0; p < GPIO_PINS; p++) begin
                pad_sel[p] <= '0;   // Team 0 owns every pad
            end
        end else begin
            ack_q <= access;
            // Index sits in the low bits of byte lane 0
            if (access && bus.we && bus.sel[0] && in_range) begin
                pad_sel[pad_idx] <= bus.wdat[TEAM_IDX_W-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            rdat_q <= in_range ? wb_dat_t'(pad_sel[pad_idx]) : '0;
        end
    end

    assign bus.ack  = ack_q;
    assign bus.rdat = rdat_q;

    // Each pad follows the team its register names
    always_comb begin
        for (int p = 0; p < GPIO_PINS; p++) begin
            io_out_o[p] = team_gpio_out_i[pad_sel[p]][p];
            io_oeb_o[p] = team_gpio_oeb_i[pad_sel[p]][p];   // Active low enable
        end
    end

endmodule

// ==== reset_sync.sv ====
/* Team reset with immediate assertion and release after two clock edges */
`timescale 1ns/1ps

module reset_sync (
    input  logic clk,
    input  logic asyncrst_n,
    output logic rst_n_o
);

    logic stage_q;

    always_ff @(posedge clk or negedge asyncrst_n) begin
        if (!asyncrst_n) begin
            stage_q <= 1'b0;
            rst_n_o <= 1'b0;
        end else begin
            stage_q <= 1'b1;
            rst_n_o <= stage_q;   // Second stage against metastability
        end
    end

endmodule

// ==== nebula_top.sv ====
/* Shared bus top level: manager ports, arbiter, decoder, RAM, GPIO control
   and the team reset synchronizer */
`timescale 1ns/1ps

module nebula_top import nebula_pkg::*; (
    input  logic       clk_i,
    input  logic       asyncrst_n_i,

    // Host processor manager
    input  logic       host_cyc_i,
    input  logic       host_stb_i,
    input  logic       host_we_i,
    input  wb_sel_t    host_sel_i,
    input  wb_adr_t    host_adr_i,
    input  wb_dat_t    host_wdat_i,
    output logic       host_ack_o,
    output wb_dat_t    host_rdat_o,

    // Team manager
    input  logic       team_cyc_i,
    input  logic       team_stb_i,
    input  logic       team_we_i,
    input  wb_sel_t    team_sel_i,
    input  wb_adr_t    team_adr_i,
    input  wb_dat_t    team_wdat_i,
    output logic       team_ack_o,
    output wb_dat_t    team_rdat_o,

    // Pads
    input  team_gpio_t team_gpio_out_i,
    input  team_gpio_t team_gpio_oeb_i,
    output gpio_bus_t  io_out_o,
    output gpio_bus_t  io_oeb_o,

    output logic       team_rst_n_o
);

    logic [NUM_MANAGERS-1:0] mgr_ack;
    wb_dat_t                 mgr_rdat;

    wb_if m_bus ();
    wb_if ram_bus ();
    wb_if gpio_bus ();

    // Manager 0 is the host, manager 1 the team
    wb_arbiter u_arbiter (
        .clk        (clk_i),
        .asyncrst_n (asyncrst_n_i),
        .m_cyc_i    ({team_cyc_i, host_cyc_i}),
        .m_stb_i    ({team_stb_i, host_stb_i}),
        .m_we_i     ({team_we_i, host_we_i}),
        .m_sel_i    ({team_sel_i, host_sel_i}),
        .m_adr_i    ({team_adr_i, host_adr_i}),
        .m_wdat_i   ({team_wdat_i, host_wdat_i}),
        .m_ack_o    (mgr_ack),
        .m_rdat_o   (mgr_rdat),
        .bus        (m_bus)
    );

    assign host_ack_o  = mgr_ack[0];
    assign team_ack_o  = mgr_ack[1];
    assign host_rdat_o = mgr_rdat;
    assign team_rdat_o = mgr_rdat;

    wb_decoder u_decoder (
        .clk        (clk_i),
        .asyncrst_n (asyncrst_n_i),
        .up         (m_bus),
        .ram        (ram_bus),
        .gpio       (gpio_bus)
    );

    ffram u_ram (
        .clk        (clk_i),
        .asyncrst_n (asyncrst_n_i),
        .bus        (ram_bus)
    );

    gpio_control u_gpio (
        .clk             (clk_i),
        .asyncrst_n      (asyncrst_n_i),
        .bus             (gpio_bus),
        .team_gpio_out_i (team_gpio_out_i),
        .team_gpio_oeb_i (team_gpio_oeb_i),
        .io_out_o        (io_out_o),
        .io_oeb_o        (io_oeb_o)
    );

    reset_sync u_team_rst (
        .clk        (clk_i),
        .asyncrst_n (asyncrst_n_i),
        .rst_n_o    (team_rst_n_o)
    );

endmodule

// ==== tb_nebula.sv ====
/* Directed testbench for the shared bus: reset, RAM byte lanes, GPIO routing,
   unmapped replies and manager contention */
`timescale 1ns/1ps

module tb_nebula import nebula_pkg::*; ();

    logic       clk;
    logic       asyncrst_n;
    logic       host_cyc, host_stb, host_we, host_ack;
    wb_sel_t    host_sel;
    wb_adr_t    host_adr;
    wb_dat_t    host_wdat, host_rdat;
    logic       team_cyc, team_stb, team_we, team_ack;
    wb_sel_t    team_sel;
    wb_adr_t    team_adr;
    wb_dat_t    team_wdat, team_rdat;
    team_gpio_t gpio_out_pat, gpio_oeb_pat;
    gpio_bus_t  io_out, io_oeb;
    logic       team_rst_n;

    int         errors = 0;
    int         tests_run = 0;
    int         host_acks = 0;
    int         team_acks = 0;
    time        host_ack_t, team_ack_t;
    wb_dat_t    ram_model [RAM_WORDS];
    team_idx_t [GPIO_PINS-1:0] pad_owner;   // Expected owner per pad

    nebula_top DUT (
        .clk_i (clk), .asyncrst_n_i (asyncrst_n),
        .host_cyc_i (host_cyc), .host_stb_i (host_stb), .host_we_i (host_we),
        .host_sel_i (host_sel), .host_adr_i (host_adr), .host_wdat_i (host_wdat),
        .host_ack_o (host_ack), .host_rdat_o (host_rdat),
        .team_cyc_i (team_cyc), .team_stb_i (team_stb), .team_we_i (team_we),
        .team_sel_i (team_sel), .team_adr_i (team_adr), .team_wdat_i (team_wdat),
        .team_ack_o (team_ack), .team_rdat_o (team_rdat),
        .team_gpio_out_i (gpio_out_pat), .team_gpio_oeb_i (gpio_oeb_pat),
        .io_out_o (io_out), .io_oeb_o (io_oeb), .team_rst_n_o (team_rst_n)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Acks counted mid-cycle where they are stable
    always @(negedge clk) begin
        if (host_ack === 1'b1) host_acks++;
        if (team_ack === 1'b1) team_acks++;
    end

    task automatic check_dat(input string name, input wb_dat_t exp, input wb_dat_t act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_gpio(input string name, input gpio_bus_t exp, input gpio_bus_t act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected %b, actual %b", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected %b, actual %b", name, exp, act);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err0);
        tests_run++;
        if (errors == err0) $display("test %s: ok", name);
        else $display("test %s: %0d errors", name, errors - err0);
    endtask

    // Byte lanes with a set select bit take the new data
    function automatic wb_dat_t merge_lanes(wb_dat_t old, wb_dat_t wdat, wb_sel_t sel);
        wb_dat_t res;
        res = old;
        for (int b = 0; b < WB_SEL_W; b++) begin
            if (sel[b]) res[b*8 +: 8] = wdat[b*8 +: 8];
        end
        return res;
    endfunction

    function automatic gpio_bus_t route_pads(team_gpio_t pat);
        gpio_bus_t res;
        for (int p = 0; p < GPIO_PINS; p++) begin
            res[p] = pat[pad_owner[p]][p];
        end
        return res;
    endfunction

    task automatic randomize_pads();
        for (int t = 0; t < NUM_TEAMS; t++) begin
            gpio_out_pat[t] = gpio_bus_t'($urandom);
            gpio_oeb_pat[t] = gpio_bus_t'($urandom);
        end
    endtask

    task automatic drive_req(input bit from_team, input logic active, input logic we,
                             input wb_sel_t sel, input wb_adr_t adr, input wb_dat_t wdat);
        if (from_team) begin
            team_cyc  = active;
            team_stb  = active;
            team_we   = we;
            team_sel  = sel;
            team_adr  = adr;
            team_wdat = wdat;
        end else begin
            host_cyc  = active;
            host_stb  = active;
            host_we   = we;
            host_sel  = sel;
            host_adr  = adr;
            host_wdat = wdat;
        end
    endtask

    // One classic cycle, request held until ack
    task automatic do_cycle(input bit from_team, input logic we, input wb_sel_t sel,
                            input wb_adr_t adr, input wb_dat_t wdat, output wb_dat_t rdat);
        int   waited;
        logic got;
        waited = 0;
        got    = 1'b0;
        rdat   = '0;
        @(posedge clk);
        #1;
        drive_req(from_team, 1'b1, we, sel, adr, wdat);
        while (!got && waited < 20) begin
            @(negedge clk);
            got = from_team ? team_ack : host_ack;
            waited++;
        end
        if (got) begin
            rdat = from_team ? team_rdat : host_rdat;
            if (from_team) team_ack_t = $time;
            else host_ack_t = $time;
        end else begin
            $display("Timeout: %s manager saw no ack within 20 cycles at address %h",
                     from_team ? "team" : "host", adr);
            errors++;
        end
        @(posedge clk);
        #1;
        drive_req(from_team, 1'b0, 1'b0, '0, '0, '0);
    endtask

    task automatic host_write(input wb_adr_t adr, input wb_sel_t sel, input wb_dat_t wdat);
        wb_dat_t unused;
        do_cycle(1'b0, 1'b1, sel, adr, wdat, unused);
    endtask

    task automatic host_read(input wb_adr_t adr, output wb_dat_t rdat);
        do_cycle(1'b0, 1'b0, 4'hF, adr, '0, rdat);
    endtask

    task automatic team_write(input wb_adr_t adr, input wb_sel_t sel, input wb_dat_t wdat);
        wb_dat_t unused;
        do_cycle(1'b1, 1'b1, sel, adr, wdat, unused);
    endtask

    task automatic team_read(input wb_adr_t adr, output wb_dat_t rdat);
        do_cycle(1'b1, 1'b0, 4'hF, adr, '0, rdat);
    endtask

    task automatic test_reset();
        int err0;
        err0 = errors;
        asyncrst_n = 1'b0;
        repeat (4) begin
            @(negedge clk);
            check_bit("reset host ack", 1'b0, host_ack);
            check_bit("reset team ack", 1'b0, team_ack);
            check_bit("reset team_rst_n", 1'b0, team_rst_n);
            check_gpio("reset io_out", gpio_out_pat[0], io_out);   // Team 0 owns all pads
            check_gpio("reset io_oeb", gpio_oeb_pat[0], io_oeb);
        end
        @(posedge clk);
        #1;
        asyncrst_n = 1'b1;
        @(negedge clk);
        check_bit("team_rst_n before first edge", 1'b0, team_rst_n);
        @(negedge clk);
        check_bit("team_rst_n after first edge", 1'b0, team_rst_n);
        @(negedge clk);
        check_bit("team_rst_n after second edge", 1'b1, team_rst_n);
        check_bit("idle host ack", 1'b0, host_ack);
        check_bit("idle team ack", 1'b0, team_ack);
        report_test("reset", err0);
    endtask

    task automatic test_ram();
        int      err0;
        wb_dat_t d;
        wb_sel_t sel;
        err0 = errors;
        // Full words first so every lane of the model is known
        for (int i = 0; i < 6; i++) begin
            d = wb_dat_t'($urandom);
            host_write(RAM_BASE + wb_adr_t'(i * 4), 4'hF, d);
            ram_model[i] = d;
        end
        for (int i = 0; i < 6; i++) begin
            sel = wb_sel_t'(1 + $urandom % 14);   // Partial lanes only
            d   = wb_dat_t'($urandom);
            host_write(RAM_BASE + wb_adr_t'(i * 4), sel, d);
            ram_model[i] = merge_lanes(ram_model[i], d, sel);
        end
        for (int i = 0; i < 6; i++) begin
            host_read(RAM_BASE + wb_adr_t'(i * 4), d);
            check_dat($sformatf("ram word %0d", i), ram_model[i], d);
        end
        ram_model[10] = wb_dat_t'($urandom);
        team_write(RAM_BASE + 32'h28, 4'hF, ram_model[10]);
        host_read(RAM_BASE + 32'h28, d);
        check_dat("ram word from team", ram_model[10], d);
        report_test("ram", err0);
    endtask

    task automatic test_gpio();
        int        err0;
        wb_dat_t   d;
        team_idx_t idx;
        err0 = errors;
        for (int p = 0; p < GPIO_PINS; p++) begin
            idx = team_idx_t'($urandom % NUM_TEAMS);
            d   = (wb_dat_t'($urandom) & ~wb_dat_t'(3)) | wb_dat_t'(idx);   // Junk above the index
            host_write(GPIO_BASE + wb_adr_t'(p * 4), 4'b0001, d);
            pad_owner[p] = idx;
        end
        for (int p = 0; p < GPIO_PINS; p++) begin
            host_read(GPIO_BASE + wb_adr_t'(p * 4), d);
            check_dat($sformatf("gpio select %0d", p), wb_dat_t'(pad_owner[p]), d);
        end
        repeat (3) begin
            @(posedge clk);
            #1;
            randomize_pads();
            @(negedge clk);
            check_gpio("gpio io_out", route_pads(gpio_out_pat), io_out);
            check_gpio("gpio io_oeb", route_pads(gpio_oeb_pat), io_oeb);
        end
        report_test("gpio", err0);
    endtask

    task automatic test_unmapped();
        int      err0;
        wb_dat_t d;
        wb_dat_t junk;
        err0 = errors;
        host_read(32'h5000_0010, d);
        check_dat("unmapped read", '0, d);
        // Low bits alias RAM word 0 and pad 0
        // Neither current value matches the data
        junk = ~ram_model[0];
        junk[TEAM_IDX_W-1:0] = pad_owner[0] + team_idx_t'(1);
        host_write(32'h4000_0000, 4'hF, junk);
        host_read(RAM_BASE, d);
        check_dat("ram after unmapped write", ram_model[0], d);
        host_read(GPIO_BASE, d);
        check_dat("gpio after unmapped write", wb_dat_t'(pad_owner[0]), d);
        report_test("unmapped", err0);
    endtask

    task automatic write_pair(input int word, input bit host_first);
        int      h0;
        int      t0;
        wb_dat_t rd;
        h0 = host_acks;
        t0 = team_acks;
        ram_model[word]     = wb_dat_t'($urandom);
        ram_model[word + 1] = wb_dat_t'($urandom);
        fork
            host_write(RAM_BASE + wb_adr_t'(word * 4), 4'hF, ram_model[word]);
            team_write(RAM_BASE + wb_adr_t'((word + 1) * 4), 4'hF, ram_model[word + 1]);
        join
        check_bit($sformatf("pair %0d host one ack", word), 1'b1, (host_acks - h0) == 1);
        check_bit($sformatf("pair %0d team one ack", word), 1'b1, (team_acks - t0) == 1);
        check_bit($sformatf("pair %0d host first", word), host_first, host_ack_t < team_ack_t);
        // Host reads leave the host as last served
        host_read(RAM_BASE + wb_adr_t'(word * 4), rd);
        check_dat($sformatf("pair %0d host word", word), ram_model[word], rd);
        host_read(RAM_BASE + wb_adr_t'((word + 1) * 4), rd);
        check_dat($sformatf("pair %0d team word", word), ram_model[word + 1], rd);
    endtask

    task automatic test_contention();
        int      err0;
        wb_dat_t rd;
        err0 = errors;
        team_read(RAM_BASE, rd);   // Team served last, host wins next
        check_dat("team read before contention", ram_model[0], rd);
        write_pair(16, 1'b1);
        write_pair(18, 1'b0);
        report_test("contention", err0);
    endtask

    initial begin
        void'($urandom(58));
        asyncrst_n = 1'b0;
        drive_req(1'b0, 1'b0, 1'b0, '0, '0, '0);
        drive_req(1'b1, 1'b0, 1'b0, '0, '0, '0);
        randomize_pads();
        pad_owner = '0;
        test_reset();
        test_ram();
        test_gpio();
        test_unmapped();
        test_contention();
        $display("Tests run: %0d, errors: %0d", tests_run, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== build.f ====
nebula_pkg.sv
wb_if.sv
wb_arbiter.sv
wb_decoder.sv
ffram.sv
gpio_control.sv
reset_sync.sv
nebula_top.sv
tb_nebula.sv

// ==== Makefile ====
TOP := tb_nebula

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing -f build.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf obj_dir
